// ==== src.f ====
+incdir+common
common/vdma_pkg.sv
rtl/beat_fifo.sv
rtl/frame_buffer_ring.sv
wr_mover/wr_mover.sv
rd_mover/rd_mover.sv
rtl/vdma_port.sv
dv/axi_mem_model.sv
dv/vdma_port_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the vdma_port testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module vdma_port_tb -o vdma_sim --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/vdma_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

// ==== dv/vdma_port_tb.sv ====
/*
 * video DMA port testbench
 * frames through the ring with random stalls, write errors and a scoreboard
 */
`include "vdma_config.svh"

module vdma_port_tb;

    localparam int frame_beats = `vdma_frame_beats;
    localparam int burst_len   = `vdma_burst_len;
    localparam int bursts      = `vdma_frame_beats / `vdma_burst_len;
    // about four cycles per beat on each side, plus reset and idle gaps
    localparam int watchdog_cycles = 40 * frame_beats * 4 * 4 + 2000;

    logic             axi4_m = 1'b0;
    logic             rst;
    logic             wr_enable;
    logic             rd_enable;
    vdma_pkg::pixel_t in_data;
    logic             in_valid;
    logic             in_user;
    logic             in_ready;
    vdma_pkg::pixel_t out_data;
    logic             out_valid;
    logic             out_user;
    logic             out_last;
    logic             out_ready;
    vdma_pkg::addr_t  awaddr;
    logic [7:0]       awlen;
    logic             awvalid;
    logic             awready;
    vdma_pkg::pixel_t wdata;
    logic             wlast;
    logic             wvalid;
    logic             wready;
    logic [1:0]       bresp;
    logic             bvalid;
    logic             bready;
    vdma_pkg::addr_t  araddr;
    logic [7:0]       arlen;
    logic             arvalid;
    logic             arready;
    vdma_pkg::pixel_t rdata;
    logic [1:0]       rresp;
    logic             rlast;
    logic             rvalid;
    logic             rready;
    logic             err_inject;
    logic [1:0]       mem_delay;

    logic [15:0]      lfsr_state = 16'd62189;
    int               err_data = 0;
    int               err_proto = 0;
    logic             in_fire = 1'b0;
    logic             rst_q = 1'b0;
    logic             committed_any = 1'b0;
    logic             rd_holding = 1'b0;
    logic             b_err = 1'b0;
    vdma_pkg::pixel_t cur_pix [frame_beats];
    vdma_pkg::pixel_t shadow [3][frame_beats];
    logic             shadow_ok [3] = '{1'b0, 1'b0, 1'b0};
    vdma_pkg::pixel_t exp_q [$];
    int               aw_n = 0;
    int               b_n = 0;
    int               r_n = 0;
    int               out_idx = 0;
    int               frames_done = 0;
    int               out_frames = 0;
    vdma_pkg::addr_t  wr_frame_base = '0;
    vdma_pkg::addr_t  held_base = '0;
    vdma_pkg::addr_t  last_base = '1;
    vdma_pkg::addr_t  prev_base = '1;

    vdma_port i_vdma_port (.*);

    axi_mem_model i_mem (.*, .delay(mem_delay));

    always #4 axi4_m = ~axi4_m;

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic is_base(input vdma_pkg::addr_t a);
        return a == `vdma_buf_base_0 || a == `vdma_buf_base_1 || a == `vdma_buf_base_2;
    endfunction

    function automatic int base_slot(input vdma_pkg::addr_t a);
        return int'(a[13:12]);
    endfunction

    // caller sits on a falling edge
    task automatic put_pixel(input vdma_pkg::pixel_t v, input logic user);
        in_data  = v;
        in_user  = user;
        in_valid = 1'b1;
        do @(negedge axi4_m); while (!in_fire);
    endtask

    task automatic send_frame(input int presync);
        logic [31:0] v;
        // junk ahead of sync must be dropped
        for (int i = 0; i < presync; i++) begin
            rand_bits(32, v);
            put_pixel(v, 1'b0);
        end
        for (int i = 0; i < frame_beats; i++) begin
            rand_bits(32, v);
            cur_pix[i] = v;
            put_pixel(v, i == 0);
        end
        in_valid = 1'b0;
        in_user  = 1'b0;
    endtask

    task automatic wait_frames(input int n);
        while (frames_done < n) @(negedge axi4_m);
    endtask

    task automatic wait_out_frames(input int n);
        int start;
        start = out_frames;
        while (out_frames < start + n) @(negedge axi4_m);
    endtask

    // random stalls on memory readies and on the sink
    always @(negedge axi4_m) begin : stall_gen
        logic [31:0] r;
        rand_bits(3, r);
        mem_delay = r[1:0];
        out_ready = r[2] | r[1];
    end

    always @(negedge axi4_m) begin
        if (rst_q) begin
            assert (!in_ready && !out_valid && !awvalid && !wvalid && !arvalid
                    && bready && rready && !i_vdma_port.wr_req && !i_vdma_port.rd_req
                    && !i_vdma_port.wr_ack && !i_vdma_port.rd_ack)
            else begin
                err_proto++;
                $display("control outputs not at reset values at %0t", $time);
            end
        end
    end

    no_early_output: assert property (@(posedge axi4_m) disable iff (rst)
        !committed_any |-> !out_valid)
    else begin
        err_proto++;
        $display("out_valid high before any frame committed at %0t", $time);
    end

    always @(posedge axi4_m) begin : monitor
        vdma_pkg::pixel_t exp;
        int               s;
        in_fire <= in_valid && in_ready;
        rst_q   <= rst;
        if (!rst) begin
            // first burst of a write frame shows the granted buffer
            if (awvalid && awready) begin
                assert (awlen == 8'(burst_len - 1)) else begin
                    err_proto++;
                    $display("FAILED awlen: expected %0d, actual %0d", burst_len - 1, awlen);
                end
                if (aw_n == 0) begin
                    wr_frame_base = awaddr;
                    assert (is_base(awaddr)) else begin
                        err_proto++;
                        $display("write frame starts at %h, not a buffer base", awaddr);
                    end
                    assert (!(rd_holding && awaddr == held_base)) else begin
                        err_proto++;
                        $display("writer granted buffer %h while the reader holds it", awaddr);
                    end
                end
                aw_n = (aw_n + 1) % bursts;
            end
            if (bvalid && bready) begin
                if (b_n == 0) b_err = 1'b0;
                if (bresp != 2'b00) b_err = 1'b1;
                if (b_n == bursts - 1) begin
                    b_n = 0;
                    frames_done++;
                    if (!b_err) begin
                        s              = base_slot(wr_frame_base);
                        shadow[s]      = cur_pix;
                        shadow_ok[s]   = 1'b1;
                        prev_base      = last_base;
                        last_base      = wr_frame_base;
                        committed_any  = 1'b1;
                    end
                end else begin
                    b_n++;
                end
            end
            // read frame start, expected data snapshot
            if (arvalid && arready && is_base(araddr)) begin
                s = base_slot(araddr);
                assert (shadow_ok[s] && (araddr == last_base || araddr == prev_base)) else begin
                    err_proto++;
                    $display("FAILED read_base: expected %h, actual %h", last_base, araddr);
                end
                rd_holding = 1'b1;
                held_base  = araddr;
                r_n        = 0;
                for (int k = 0; k < frame_beats; k++) exp_q.push_back(shadow[s][k]);
            end
            if (rvalid && rready) begin
                r_n++;
                if (r_n == frame_beats) rd_holding = 1'b0;
            end
            if (out_valid && out_ready) begin
                assert (exp_q.size() != 0) else begin
                    err_proto++;
                    $display("output beat with no frame read behind it");
                end
                if (exp_q.size() != 0) begin
                    exp = exp_q.pop_front();
                    assert (out_data == exp) else begin
                        err_data++;
                        $display("FAILED round_trip beat %0d: expected %h, actual %h",
                                 out_idx, exp, out_data);
                    end
                    assert (out_user == (out_idx == 0)) else begin
                        err_data++;
                        $display("FAILED out_user beat %0d: expected %0d, actual %0d",
                                 out_idx, out_idx == 0, out_user);
                    end
                    assert (out_last == (out_idx == frame_beats - 1)) else begin
                        err_data++;
                        $display("FAILED out_last beat %0d: expected %0d, actual %0d",
                                 out_idx, out_idx == frame_beats - 1, out_last);
                    end
                end
                if (out_idx == frame_beats - 1) begin
                    out_idx = 0;
                    out_frames++;
                end else begin
                    out_idx++;
                end
            end
        end
    end

    initial begin
        rst        = 1'b1;
        wr_enable  = 1'b0;
        rd_enable  = 1'b0;
        in_data    = '0;
        in_valid   = 1'b0;
        in_user    = 1'b0;
        out_ready  = 1'b1;
        err_inject = 1'b0;
        mem_delay  = 2'b00;
        repeat (16) @(posedge axi4_m);
        @(negedge axi4_m);
        rst = 1'b0;
        // reader enabled early, nothing may come out yet
        rd_enable = 1'b1;
        repeat (40) @(negedge axi4_m);
        wr_enable = 1'b1;
        for (int f = 0; f < 6; f++) begin
            send_frame(f % 3);
            wait_frames(f + 1);
        end
        wait_out_frames(2);
        // park the reader, then write a frame that gets SLVERR
        rd_enable = 1'b0;
        // reader finishes its frame and releases the buffer
        while (i_vdma_port.rd_req) @(negedge axi4_m);
        while (rd_holding || exp_q.size() != 0) @(negedge axi4_m);
        err_inject = 1'b1;
        send_frame(2);
        wait_frames(7);
        err_inject = 1'b0;
        rd_enable  = 1'b1;
        wait_out_frames(2);
        for (int f = 7; f < 9; f++) begin
            send_frame(1);
            wait_frames(f + 1);
        end
        wait_out_frames(2);
        $display("errors: data %0d, protocol %0d", err_data, err_proto);
        if (err_data + err_proto == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge axi4_m);
        $display("timeout: run did not finish within %0d cycles, errors: data %0d, protocol %0d",
                 watchdog_cycles, err_data, err_proto);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== dv/axi_mem_model.sv ====
/*
 * AXI4 slave memory model
 * incrementing bursts, random ready stalls, SLVERR while err_inject is set
 */
`include "vdma_config.svh"

module axi_mem_model (
    input  logic                    axi4_m,
    input  logic                    rst,
    input  logic                    err_inject,
    input  logic [1:0]              delay,
    input  logic [`vdma_addr_w-1:0] awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`vdma_data_w-1:0] wdata,
    input  logic                    wlast,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [`vdma_addr_w-1:0] araddr,
    input  logic [7:0]              arlen,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [`vdma_data_w-1:0] rdata,
    output logic [1:0]              rresp,
    output logic                    rlast,
    output logic                    rvalid,
    input  logic                    rready
);

    logic [`vdma_data_w-1:0] mem [4096];
    logic [`vdma_addr_w-1:0] ar_a [4];
    logic [7:0]              ar_l [4];
    logic [1:0]              q_wp;
    logic [1:0]              q_rp;
    logic [2:0]              q_n;
    logic                    w_act;
    logic                    b_pend;
    logic                    r_act;
    logic [`vdma_addr_w-1:0] w_addr;
    logic [`vdma_addr_w-1:0] r_addr;
    logic [8:0]              r_left;
    logic                    ar_push;
    logic                    ar_pop;

    // fill word depends on the whole word address
    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i] = {16'(i) ^ 16'ha5c3, 16'(i)};
        end
    end

    // wlast closes the write burst
    assign awready = !w_act && !delay[0];
    assign wready  = w_act && !b_pend && !delay[1];
    assign bvalid  = b_pend;
    assign bresp   = err_inject ? 2'b10 : 2'b00;
    // up to four read bursts queued
    assign arready = q_n < 3'd4 && !delay[0];
    assign rvalid  = r_act && !delay[1];
    assign rdata   = mem[r_addr[13:2]];
    assign rresp   = err_inject ? 2'b10 : 2'b00;
    assign rlast   = r_left == 9'd1;
    assign ar_push = arvalid && arready;
    assign ar_pop  = !r_act && q_n != 3'd0;

    always @(posedge axi4_m) begin
        if (rst) begin
            w_act  <= 1'b0;
            b_pend <= 1'b0;
            r_act  <= 1'b0;
            q_wp   <= '0;
            q_rp   <= '0;
            q_n    <= '0;
        end else begin
            if (awvalid && awready) begin
                w_act  <= 1'b1;
                w_addr <= awaddr;
            end
            if (wvalid && wready) begin
                mem[w_addr[13:2]] <= wdata;
                w_addr            <= w_addr + 4;
                if (wlast) b_pend <= 1'b1;
            end
            if (bvalid && bready) begin
                b_pend <= 1'b0;
                w_act  <= 1'b0;
            end
            if (ar_push) begin
                ar_a[q_wp] <= araddr;
                ar_l[q_wp] <= arlen;
                q_wp       <= q_wp + 1'b1;
            end
            // next burst starts once the current one has ended
            if (ar_pop) begin
                r_act  <= 1'b1;
                r_addr <= ar_a[q_rp];
                r_left <= {1'b0, ar_l[q_rp]} + 9'd1;
                q_rp   <= q_rp + 1'b1;
            end
            q_n <= q_n + 3'(ar_push) - 3'(ar_pop);
            if (rvalid && rready) begin
                r_addr <= r_addr + 4;
                r_left <= r_left - 9'd1;
                if (rlast) r_act <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/vdma_port.sv ====
/*
 * video DMA port
 * pixel stream into a frame buffer ring in AXI4 memory and back out
 */
module vdma_port (
    input  logic             axi4_m,
    input  logic             rst,
    input  logic             wr_enable,
    input  logic             rd_enable,
    // stream in
    input  vdma_pkg::pixel_t in_data,
    input  logic             in_valid,
    input  logic             in_user,
    output logic             in_ready,
    // stream out
    output vdma_pkg::pixel_t out_data,
    output logic             out_valid,
    output logic             out_user,
    output logic             out_last,
    input  logic             out_ready,
    // AXI4 write
    output vdma_pkg::addr_t  awaddr,
    output logic [7:0]       awlen,
    output logic             awvalid,
    input  logic             awready,
    output vdma_pkg::pixel_t wdata,
    output logic             wlast,
    output logic             wvalid,
    input  logic             wready,
    input  logic [1:0]       bresp,
    input  logic             bvalid,
    output logic             bready,
    // AXI4 read
    output vdma_pkg::addr_t  araddr,
    output logic [7:0]       arlen,
    output logic             arvalid,
    input  logic             arready,
    input  vdma_pkg::pixel_t rdata,
    input  logic [1:0]       rresp,
    input  logic             rlast,
    input  logic             rvalid,
    output logic             rready
);

    logic            wr_req;
    logic            wr_ack;
    logic            wr_commit;
    vdma_pkg::addr_t wr_base;
    logic            rd_req;
    logic            rd_ack;
    vdma_pkg::addr_t rd_base;

    frame_buffer_ring i_ring (
        .axi4_m, .rst, .wr_req, .wr_commit, .rd_req, .wr_ack, .wr_base, .rd_ack, .rd_base
    );

    wr_mover i_wr_mover (
        .axi4_m, .rst, .wr_enable, .in_data, .in_valid, .in_user, .wr_ack, .wr_base,
        .awready, .wready, .bresp, .bvalid, .in_ready, .wr_req, .wr_commit,
        .awaddr, .awlen, .awvalid, .wdata, .wlast, .wvalid, .bready
    );

    rd_mover i_rd_mover (
        .axi4_m, .rst, .rd_enable, .rd_ack, .rd_base, .arready, .rdata, .rresp, .rlast,
        .rvalid, .out_ready, .rd_req, .araddr, .arlen, .arvalid, .rready,
        .out_data, .out_valid, .out_user, .out_last
    );

endmodule

// ==== rd_mover/rd_mover.sv ====
/*
 * read mover
 * reads the granted frame in AXI bursts, flow controlled by fifo credit
 */
`include "vdma_config.svh"

module rd_mover (
    input  logic             axi4_m,
    input  logic             rst,
    input  logic             rd_enable,
    input  logic             rd_ack,
    input  vdma_pkg::addr_t  rd_base,
    input  logic             arready,
    input  vdma_pkg::pixel_t rdata,
    input  logic [1:0]       rresp,
    input  logic             rlast,
    input  logic             rvalid,
    input  logic             out_ready,
    output logic             rd_req,
    output vdma_pkg::addr_t  araddr,
    output logic [7:0]       arlen,
    output logic             arvalid,
    output logic             rready,
    output vdma_pkg::pixel_t out_data,
    output logic             out_valid,
    output logic             out_user,
    output logic             out_last
);

    localparam int cnt_w = $clog2(`vdma_fifo_depth + 1);
    localparam vdma_pkg::beat_cnt_t frame_beats = `vdma_frame_beats;
    localparam vdma_pkg::beat_cnt_t burst_beats = `vdma_burst_len;

    typedef enum logic [1:0] {st_off, st_run, st_drain, st_rel} rd_st_t;

    rd_st_t              state;
    vdma_pkg::beat_cnt_t ar_off;
    vdma_pkg::beat_cnt_t rd_cnt;
    logic [cnt_w-1:0]    pend;
    logic [cnt_w-1:0]    fifo_count;
    logic                fifo_empty;
    vdma_pkg::rd_beat_t  push_beat;
    vdma_pkg::rd_beat_t  pop_beat;
    logic                push;
    logic                room;
    logic                r_err;
    logic                ar_fire;

    assign ar_fire = arvalid && arready;
    assign r_err   = rresp != 2'b00;
    // queued plus outstanding plus one more burst must fit
    assign room    = (fifo_count + pend + `vdma_burst_len) <= `vdma_fifo_depth;

    // beats outside a running frame are dropped
    assign push           = rvalid && state == st_run;
    assign push_beat.sof  = rd_cnt == 0;
    assign push_beat.eof  = r_err || rlast && rd_cnt == frame_beats - 1'b1;
    assign push_beat.data = rdata;

    beat_fifo #(.payload_t(vdma_pkg::rd_beat_t)) i_return (
        .axi4_m, .rst, .push, .push_data(push_beat), .pop(out_valid && out_ready),
        .pop_data(pop_beat), .count(fifo_count), .full(), .empty(fifo_empty)
    );

    assign araddr    = rd_base + (vdma_pkg::addr_t'(ar_off) << $clog2(`vdma_data_w / 8));
    assign arlen     = 8'(`vdma_burst_len - 1);
    assign rready    = 1'b1;
    assign out_valid = !fifo_empty;
    assign out_data  = pop_beat.data;
    assign out_user  = pop_beat.sof;
    assign out_last  = pop_beat.eof;

    always_ff @(posedge axi4_m) begin
        if (rst) begin
            state   <= st_off;
            rd_req  <= 1'b0;
            arvalid <= 1'b0;
            ar_off  <= '0;
            rd_cnt  <= '0;
            pend    <= '0;
        end else begin
            // outstanding beat credit
            case ({ar_fire, rvalid})
                2'b10:   pend <= pend + cnt_w'(`vdma_burst_len);
                2'b01:   pend <= pend - 1'b1;
                2'b11:   pend <= pend + cnt_w'(`vdma_burst_len - 1);
                default: pend <= pend;
            endcase
            if (ar_fire) begin
                arvalid <= 1'b0;
                ar_off  <= ar_off + burst_beats;
            end
            case (state)
                st_off: if (rd_enable && !rd_ack) begin
                    rd_req <= 1'b1;
                    ar_off <= '0;
                    rd_cnt <= '0;
                    state  <= st_run;
                end
                st_run: begin
                    if (!arvalid && rd_ack && room && ar_off != frame_beats) arvalid <= 1'b1;
                    if (rvalid) begin
                        rd_cnt <= rd_cnt + 1'b1;
                        if (r_err) begin
                            // frame cut short, flush what is still in flight
                            state <= st_drain;
                        end else if (rd_cnt == frame_beats - 1'b1) begin
                            rd_req <= 1'b0;
                            state  <= st_rel;
                        end
                    end
                end
                st_drain: if (!arvalid && pend == 0) begin
                    rd_req <= 1'b0;
                    state  <= st_rel;
                end
                default: if (!rd_ack) state <= st_off;
            endcase
        end
    end

endmodule

// ==== wr_mover/wr_mover.sv ====
/*
 * write mover
 * syncs on in_user, stages one frame of pixels and writes AXI bursts
 */
`include "vdma_config.svh"

module wr_mover (
    input  logic             axi4_m,
    input  logic             rst,
    input  logic             wr_enable,
    input  vdma_pkg::pixel_t in_data,
    input  logic             in_valid,
    input  logic             in_user,
    input  logic             wr_ack,
    input  vdma_pkg::addr_t  wr_base,
    input  logic             awready,
    input  logic             wready,
    input  logic [1:0]       bresp,
    input  logic             bvalid,
    output logic             in_ready,
    output logic             wr_req,
    output logic             wr_commit,
    output vdma_pkg::addr_t  awaddr,
    output logic [7:0]       awlen,
    output logic             awvalid,
    output vdma_pkg::pixel_t wdata,
    output logic             wlast,
    output logic             wvalid,
    output logic             bready
);

    localparam int cnt_w = $clog2(`vdma_fifo_depth + 1);
    localparam vdma_pkg::beat_cnt_t frame_beats = `vdma_frame_beats;
    localparam vdma_pkg::beat_cnt_t burst_beats = `vdma_burst_len;

    typedef enum logic [1:0] {st_off, st_hunt, st_fill, st_done} frame_st_t;
    typedef enum logic [1:0] {b_idle, b_aw, b_w, b_b} burst_st_t;

    frame_st_t                            state;
    burst_st_t                            bstate;
    vdma_pkg::beat_cnt_t                  pix_cnt;
    vdma_pkg::beat_cnt_t                  wr_off;
    logic [$clog2(`vdma_burst_len)-1:0]   w_beat;
    logic [cnt_w-1:0]                     fifo_count;
    logic                                 fifo_full;
    logic                                 fifo_empty;
    logic                                 push;
    logic                                 b_last;

    // hunting drops beats, filling stops at a full fifo or a full frame
    assign in_ready = (state == st_hunt)
                   || (state == st_fill && !fifo_full && pix_cnt != frame_beats);
    assign push     = in_valid && in_ready && (state == st_fill || in_user);

    beat_fifo #(.payload_t(vdma_pkg::pixel_t)) i_stage (
        .axi4_m, .rst, .push, .push_data(in_data), .pop(wvalid && wready),
        .pop_data(wdata), .count(fifo_count), .full(fifo_full), .empty(fifo_empty)
    );

    // byte address from the beat offset
    assign awaddr  = wr_base + (vdma_pkg::addr_t'(wr_off) << $clog2(`vdma_data_w / 8));
    assign awlen   = 8'(`vdma_burst_len - 1);
    assign awvalid = bstate == b_aw;
    assign wvalid  = bstate == b_w && !fifo_empty;
    assign wlast   = w_beat == ($clog2(`vdma_burst_len))'(`vdma_burst_len - 1);
    assign bready  = 1'b1;
    // last response of the frame
    assign b_last  = bstate == b_b && bvalid && wr_off == frame_beats;

    always_ff @(posedge axi4_m) begin
        if (rst) begin
            state     <= st_off;
            wr_req    <= 1'b0;
            wr_commit <= 1'b0;
            pix_cnt   <= '0;
        end else begin
            case (state)
                st_off: if (wr_enable && !wr_ack) state <= st_hunt;
                st_hunt: begin
                    if (!wr_enable) begin
                        state <= st_off;
                    end else if (in_valid && in_user) begin
                        // first pixel goes into the fifo this cycle
                        state     <= st_fill;
                        wr_req    <= 1'b1;
                        wr_commit <= 1'b1;
                        pix_cnt   <= 1;
                    end
                end
                st_fill: begin
                    if (push) pix_cnt <= pix_cnt + 1'b1;
                    // any error spoils the whole frame
                    if (bstate == b_b && bvalid && bresp != 2'b00) wr_commit <= 1'b0;
                    if (b_last) begin
                        wr_req <= 1'b0;
                        state  <= st_done;
                    end
                end
                default: if (!wr_ack) state <= st_off;
            endcase
        end
    end

    // one burst in flight, AW only once a whole burst is staged
    always_ff @(posedge axi4_m) begin
        if (rst) begin
            bstate <= b_idle;
            wr_off <= '0;
            w_beat <= '0;
        end else begin
            case (bstate)
                b_idle: begin
                    if (state == st_hunt) begin
                        wr_off <= '0;
                    end else if (state == st_fill && wr_ack && wr_off != frame_beats
                                 && fifo_count >= `vdma_burst_len) begin
                        bstate <= b_aw;
                    end
                end
                b_aw: if (awready) begin
                    bstate <= b_w;
                    wr_off <= wr_off + burst_beats;
                    w_beat <= '0;
                end
                b_w: if (wvalid && wready) begin
                    w_beat <= w_beat + 1'b1;
                    if (wlast) bstate <= b_b;
                end
                default: if (bvalid) bstate <= b_idle;
            endcase
        end
    end

endmodule

// ==== rtl/frame_buffer_ring.sv ====
/*
 * frame buffer ring
 * triple buffer ownership, four-phase grants to writer and reader
 */
`include "vdma_config.svh"

module frame_buffer_ring (
    input  logic            axi4_m,
    input  logic            rst,
    input  logic            wr_req,
    input  logic            wr_commit,
    input  logic            rd_req,
    output logic            wr_ack,
    output vdma_pkg::addr_t wr_base,
    output logic            rd_ack,
    output vdma_pkg::addr_t rd_base
);

    vdma_pkg::buf_idx_t last_idx;
    vdma_pkg::buf_idx_t wr_idx;
    vdma_pkg::buf_idx_t rd_idx;
    vdma_pkg::buf_idx_t free_idx;
    logic               has_commit;

    function automatic vdma_pkg::addr_t idx_to_base(input vdma_pkg::buf_idx_t idx);
        case (idx)
            2'd1:    return `vdma_buf_base_1;
            2'd2:    return `vdma_buf_base_2;
            default: return `vdma_buf_base_0;
        endcase
    endfunction

    // lowest buffer that is neither last committed nor held by the reader
    // two exclusions at most, so one of three is always free
    always_comb begin
        free_idx = 2'd0;
        for (int i = 2; i >= 0; i--) begin
            if (!(has_commit && last_idx == i) && !(rd_ack && rd_idx == i)) begin
                free_idx = vdma_pkg::buf_idx_t'(i);
            end
        end
    end

    always_ff @(posedge axi4_m) begin
        if (rst) begin
            wr_ack     <= 1'b0;
            rd_ack     <= 1'b0;
            has_commit <= 1'b0;
            last_idx   <= '0;
            wr_idx     <= '0;
            rd_idx     <= '0;
        end else begin
            // write side, commit sampled as req falls
            if (wr_req && !wr_ack) begin
                wr_ack <= 1'b1;
                wr_idx <= free_idx;
            end else if (!wr_req && wr_ack) begin
                wr_ack <= 1'b0;
                if (wr_commit) begin
                    last_idx   <= wr_idx;
                    has_commit <= 1'b1;
                end
            end
            // read side waits for a first good frame
            if (rd_req && !rd_ack && has_commit) begin
                rd_ack <= 1'b1;
                rd_idx <= last_idx;
            end else if (!rd_req && rd_ack) begin
                rd_ack <= 1'b0;
            end
        end
    end

    // bases hold while the matching ack is high
    assign wr_base = idx_to_base(wr_idx);
    assign rd_base = idx_to_base(rd_idx);

endmodule

// ==== rtl/beat_fifo.sv ====
/*
 * beat FIFO
 * register array with show-ahead read, payload type set per instance
 */
`include "vdma_config.svh"

module beat_fifo #(
    parameter type payload_t = vdma_pkg::pixel_t
) (
    input  logic                                   axi4_m,
    input  logic                                   rst,
    input  logic                                   push,
    input  payload_t                               push_data,
    input  logic                                   pop,
    output payload_t                               pop_data,
    output logic [$clog2(`vdma_fifo_depth+1)-1:0]  count,
    output logic                                   full,
    output logic                                   empty
);

    localparam int depth = `vdma_fifo_depth;
    localparam int ptr_w = $clog2(depth);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    // overflow and underflow are ignored
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge axi4_m) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge axi4_m) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // head entry visible without a pop
    assign pop_data = mem[rd_ptr];
    assign full     = count == depth;
    assign empty    = count == 0;

endmodule

// ==== common/vdma_pkg.sv ====
/*
 * video DMA shared types
 * addresses, pixels, tagged read beats and counters
 */
`include "vdma_config.svh"

package vdma_pkg;

    // byte address on the AXI bus
    typedef logic [`vdma_addr_w-1:0] addr_t;

    // one pixel is exactly one AXI beat
    typedef logic [`vdma_data_w-1:0] pixel_t;

    // read beat plus frame markers for the output stream
    typedef struct packed {
        logic   sof;
        logic   eof;
        pixel_t data;
    } rd_beat_t;

    // wide enough to hold the full frame count itself
    typedef logic [$clog2(`vdma_frame_beats):0] beat_cnt_t;

    // buffer number 0..2
    typedef logic [1:0] buf_idx_t;

endpackage

// ==== common/vdma_config.svh ====
/*
 * video DMA port configuration
 * bus widths, burst shape, frame size and frame buffer bases
 */
`ifndef VDMA_CONFIG_SVH
`define VDMA_CONFIG_SVH

// byte address and beat widths
`define vdma_addr_w       32
`define vdma_data_w       32

// beats per burst, frame is a whole number of bursts
`define vdma_burst_len    8
`define vdma_frame_beats  32

// three frame buffers in external memory
`define vdma_buf_base_0   32'h0000_0000
`define vdma_buf_base_1   32'h0000_1000
`define vdma_buf_base_2   32'h0000_2000

`define vdma_fifo_depth   16

`endif
